// File: Bender.yml
package:
  name: lsu

sources:
  - files:
      - hdl/lsu_pkg.sv
      - hdl/lsu_data_align.sv
      - hdl/lsu_ctrl.sv
      - hdl/axi_mem_slave.sv
      - hdl/lsu_top.sv
  - target: simulation
    files:
      - verification/tb_clk_gen.sv
      - verification/lsu_checker.sv
      - verification/lsu_tb.sv

// File: hdl/axi_mem_slave.sv
`timescale 1ns/1ns

module axi_mem_slave #(
    parameter logic [31:0] MEM_BASE   = 32'h8000_0000,
    parameter int          MEM_WORDS  = 1024,
    parameter int          RESP_DELAY = 0
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             awvalid,
    output logic             awready,
    input  lsu_pkg::axi_aw_t aw,
    input  logic             wvalid,
    output logic             wready,
    input  lsu_pkg::axi_w_t  w,
    output logic             bvalid,
    input  logic             bready,
    output lsu_pkg::axi_b_t  b,
    input  logic             arvalid,
    output logic             arready,
    input  lsu_pkg::axi_ar_t ar,
    output logic             rvalid,
    input  logic             rready,
    output lsu_pkg::axi_r_t  r
);
    import lsu_pkg::*;

    localparam int          IDX_W     = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int          CNT_W     = $clog2(RESP_DELAY + 2);
    localparam logic [31:0] WIN_BYTES = MEM_WORDS * 4;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_RESP
    } state_e;

    logic [31:0] mem [MEM_WORDS];

    state_e             state;
    logic [CNT_W-1:0]   cnt;
    logic               wr_fire;
    logic               rd_fire;
    logic [31:0]        acc_addr;
    logic [31:0]        acc_off;
    logic               acc_in_range;
    logic [IDX_W-1:0]   acc_idx;
    logic               rsp_is_wr;
    logic [3:0]         rsp_id;
    logic [1:0]         rsp_resp;
    logic [31:0]        rsp_data;

    // AW is only taken together with W.
    assign awready = (state == S_IDLE) && wvalid;
    assign wready  = (state == S_IDLE) && awvalid;
    assign arready = (state == S_IDLE) && !awvalid;

    assign wr_fire = awvalid && awready && wvalid && wready;
    assign rd_fire = arvalid && arready;

    assign acc_addr     = wr_fire ? aw.addr : ar.addr;
    assign acc_off      = acc_addr - MEM_BASE;
    assign acc_in_range = (acc_addr >= MEM_BASE) && (acc_off < WIN_BYTES);
    assign acc_idx      = acc_off[IDX_W+1:2];

    assign b = '{id: rsp_id, resp: rsp_resp};
    assign r = '{id: rsp_id, resp: rsp_resp, data: rsp_data, last: 1'b1};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= S_IDLE;
            cnt    <= '0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (wr_fire || rd_fire) begin
                        state <= S_WAIT;
                        cnt   <= '0;
                    end
                end
                S_WAIT: begin
                    if (cnt == CNT_W'(RESP_DELAY)) begin
                        state  <= S_RESP;
                        bvalid <= rsp_is_wr;
                        rvalid <= !rsp_is_wr;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_RESP: begin
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        state  <= S_IDLE;
                        bvalid <= 1'b0;
                        rvalid <= 1'b0;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // response payload and memory array.
    always_ff @(posedge clk) begin
        if (wr_fire || rd_fire) begin
            rsp_is_wr <= wr_fire;
            rsp_id    <= wr_fire ? aw.id : ar.id;
            rsp_resp  <= acc_in_range ? axi_resp_okay : axi_resp_slverr;
        end
        if (rd_fire) begin
            rsp_data <= acc_in_range ? mem[acc_idx] : 32'h0;
        end
        if (wr_fire && acc_in_range) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i]) begin
                    mem[acc_idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: hdl/lsu_ctrl.sv
`timescale 1ns/1ns

module lsu_ctrl #(
    parameter logic [31:0] SDRAM_BASE  = 32'ha000_0000,
    parameter logic [31:0] SDRAM_LIMIT = 32'hbfff_ffff
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               req_valid,
    input  lsu_pkg::lsu_req_t  req,
    output logic               req_ready,
    output logic               resp_valid,
    output lsu_pkg::lsu_resp_t resp,

    output logic [1:0]         addr_off,
    output lsu_pkg::mem_size_e size,
    output logic               sign_ext,
    output logic [31:0]        store_data,
    input  logic [31:0]        lane_data,
    input  logic [3:0]         strb,
    input  logic [31:0]        load_value,

    output logic               awvalid,
    input  logic               awready,
    output lsu_pkg::axi_aw_t   aw,
    output logic               wvalid,
    input  logic               wready,
    output lsu_pkg::axi_w_t    w,
    input  logic               bvalid,
    output logic               bready,
    input  lsu_pkg::axi_b_t    b,
    output logic               arvalid,
    input  logic               arready,
    output lsu_pkg::axi_ar_t   ar,
    input  logic               rvalid,
    output logic               rready,
    input  lsu_pkg::axi_r_t    r,

    output logic [31:0]        r_data
);
    import lsu_pkg::*;

    typedef enum logic {
        IDLE,
        BUSY
    } state_e;

    state_e     state;
    lsu_req_t   req_q;
    logic       accept;
    logic       req_is_mem;
    logic       done_r;
    logic       done_b;
    logic       in_sdram;
    logic [1:0] burst;

    assign req_ready  = (state == IDLE);
    assign accept     = req_valid && req_ready;
    assign req_is_mem = req.op.read || req.op.write;
    assign done_r     = rvalid && rready;
    assign done_b     = bvalid && bready;

    // sdram region is served with INCR bursts.
    assign in_sdram = (req_q.addr >= SDRAM_BASE) && (req_q.addr <= SDRAM_LIMIT);
    assign burst    = in_sdram ? axi_burst_incr : axi_burst_fixed;

    // aligner works on the held request.
    assign addr_off   = req_q.addr[1:0];
    assign size       = req_q.op.size;
    assign sign_ext   = req_q.op.sign_ext;
    assign store_data = req_q.wdata;
    assign r_data     = r.data;

    // channel payloads stay stable while the request is held.
    assign aw = '{addr: req_q.addr, id: 4'h0, len: 8'h00,
                  size: {1'b0, req_q.op.size}, burst: burst};
    assign ar = '{addr: req_q.addr, id: 4'h0, len: 8'h00,
                  size: {1'b0, req_q.op.size}, burst: burst};
    assign w  = '{data: lane_data, strb: strb, last: 1'b1};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            resp_valid <= 1'b0;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            bready     <= 1'b0;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= BUSY;
                        if (req.op.read) begin
                            arvalid <= 1'b1;
                        end else if (req.op.write) begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                        end else begin
                            resp_valid <= 1'b1;
                        end
                    end
                end
                BUSY: begin
                    // back to IDLE once the response cycle is over.
                    if (resp_valid) begin
                        state <= IDLE;
                    end
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                        bready  <= 1'b1;
                    end
                    if (wvalid && wready) begin
                        wvalid <= 1'b0;
                    end
                    if (done_r || done_b) begin
                        rready     <= 1'b0;
                        bready     <= 1'b0;
                        resp_valid <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (accept && !req_is_mem) begin
            resp <= '{pc: req.pc, rd: req.rd, tag: req.tag, result: req.addr, fault: 1'b0};
        end else if (done_r) begin
            resp <= '{pc: req_q.pc, rd: req_q.rd, tag: req_q.tag, result: load_value,
                      fault: (r.resp != axi_resp_okay)};
        end else if (done_b) begin
            resp <= '{pc: req_q.pc, rd: req_q.rd, tag: req_q.tag, result: req_q.addr,
                      fault: (b.resp != axi_resp_okay)};
        end
    end

endmodule

// File: hdl/lsu_data_align.sv
`timescale 1ns/1ns

module lsu_data_align (
    input  logic [1:0]         addr_off,
    input  lsu_pkg::mem_size_e size,
    input  logic               sign_ext,
    input  logic [31:0]        store_data,
    input  logic [31:0]        load_word,
    output logic [31:0]        lane_data,
    output logic [3:0]         strb,
    output logic [31:0]        load_value
);
    import lsu_pkg::*;

    logic [4:0]  bit_off;
    logic [31:0] load_shifted;

    assign bit_off = {addr_off, 3'b000};

    // store side moves the low bytes up to their lanes.
    assign lane_data = store_data << bit_off;

    always_comb begin
        case (size)
            MEM_BYTE: strb = 4'b0001 << addr_off;
            MEM_HALF: strb = 4'b0011 << addr_off;
            MEM_WORD: strb = 4'b1111;
            default:  strb = 4'b0000;
        endcase
    end

    // load side brings the lane down to bit 0 first.
    assign load_shifted = load_word >> bit_off;

    always_comb begin
        case (size)
            MEM_BYTE: begin
                load_value = {{24{sign_ext & load_shifted[7]}}, load_shifted[7:0]};
            end
            MEM_HALF: begin
                load_value = {{16{sign_ext & load_shifted[15]}}, load_shifted[15:0]};
            end
            default: begin
                load_value = load_shifted;
            end
        endcase
    end

endmodule

// File: hdl/lsu_pkg.sv
package lsu_pkg;

    // access size, also the AXI size field once widened to 3 bits.
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_e;

    typedef struct packed {
        logic      read;
        logic      write;
        mem_size_e size;
        logic      sign_ext;
    } lsu_op_t;

    // request from the execute stage.
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        lsu_op_t     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [7:0]  tag;
    } lsu_req_t;

    // response towards writeback.
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [7:0]  tag;
        logic [31:0] result;
        logic        fault;
    } lsu_resp_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [3:0] id;
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [1:0]  resp;
        logic [31:0] data;
        logic        last;
    } axi_r_t;

    localparam logic [1:0] axi_resp_okay   = 2'b00;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

    localparam logic [1:0] axi_burst_fixed = 2'b00;
    localparam logic [1:0] axi_burst_incr  = 2'b01;

endpackage

// File: hdl/lsu_top.sv
`timescale 1ns/1ns

module lsu_top #(
    parameter logic [31:0] SDRAM_BASE  = 32'ha000_0000,
    parameter logic [31:0] SDRAM_LIMIT = 32'hbfff_ffff,
    parameter logic [31:0] MEM_BASE    = 32'h8000_0000,
    parameter int          MEM_WORDS   = 1024,
    parameter int          RESP_DELAY  = 0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  lsu_pkg::lsu_req_t  req,
    output logic               req_ready,
    output logic               resp_valid,
    output lsu_pkg::lsu_resp_t resp
);
    import lsu_pkg::*;

    // aligner side.
    logic [1:0]  addr_off;
    mem_size_e   size;
    logic        sign_ext;
    logic [31:0] store_data;
    logic [31:0] lane_data;
    logic [3:0]  strb;
    logic [31:0] load_value;
    logic [31:0] r_data;

    // AXI4 channels.
    logic    awvalid;
    logic    awready;
    axi_aw_t aw;
    logic    wvalid;
    logic    wready;
    axi_w_t  w;
    logic    bvalid;
    logic    bready;
    axi_b_t  b;
    logic    arvalid;
    logic    arready;
    axi_ar_t ar;
    logic    rvalid;
    logic    rready;
    axi_r_t  r;

    lsu_ctrl #(
        .SDRAM_BASE  (SDRAM_BASE),
        .SDRAM_LIMIT (SDRAM_LIMIT)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .addr_off   (addr_off),
        .size       (size),
        .sign_ext   (sign_ext),
        .store_data (store_data),
        .lane_data  (lane_data),
        .strb       (strb),
        .load_value (load_value),
        .awvalid    (awvalid),
        .awready    (awready),
        .aw         (aw),
        .wvalid     (wvalid),
        .wready     (wready),
        .w          (w),
        .bvalid     (bvalid),
        .bready     (bready),
        .b          (b),
        .arvalid    (arvalid),
        .arready    (arready),
        .ar         (ar),
        .rvalid     (rvalid),
        .rready     (rready),
        .r          (r),
        .r_data     (r_data)
    );

    lsu_data_align u_align (
        .addr_off   (addr_off),
        .size       (size),
        .sign_ext   (sign_ext),
        .store_data (store_data),
        .load_word  (r_data),
        .lane_data  (lane_data),
        .strb       (strb),
        .load_value (load_value)
    );

    axi_mem_slave #(
        .MEM_BASE   (MEM_BASE),
        .MEM_WORDS  (MEM_WORDS),
        .RESP_DELAY (RESP_DELAY)
    ) u_mem (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .aw      (aw),
        .wvalid  (wvalid),
        .wready  (wready),
        .w       (w),
        .bvalid  (bvalid),
        .bready  (bready),
        .b       (b),
        .arvalid (arvalid),
        .arready (arready),
        .ar      (ar),
        .rvalid  (rvalid),
        .rready  (rready),
        .r       (r)
    );

endmodule

// File: verification/lsu_checker.sv
`timescale 1ns/1ns

module lsu_checker (
    input logic             clk,
    input logic             rst,
    input logic             req_ready,
    input logic             resp_valid,
    input logic             awvalid,
    input logic             awready,
    input lsu_pkg::axi_aw_t aw,
    input logic             wvalid,
    input logic             wready,
    input lsu_pkg::axi_w_t  w,
    input logic             arvalid,
    input logic             arready,
    input lsu_pkg::axi_ar_t ar
);

    // a raised valid holds its payload until the handshake.
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("AW valid dropped or payload changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("W valid dropped or payload changed before wready");

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("AR valid dropped or payload changed before arready");

    rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(arvalid && awvalid))
        else $error("arvalid and awvalid high together");

    resp_pulse: assert property (@(posedge clk) disable iff (rst)
        resp_valid |=> !resp_valid)
        else $error("resp_valid held longer than one cycle");

    // no new request while a transaction is on the bus.
    busy_not_ready: assert property (@(posedge clk) disable iff (rst)
        (awvalid || wvalid || arvalid) |-> !req_ready)
        else $error("req_ready high while an AXI valid is high");

endmodule

bind lsu_ctrl lsu_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .awvalid    (awvalid),
    .awready    (awready),
    .aw         (aw),
    .wvalid     (wvalid),
    .wready     (wready),
    .w          (w),
    .arvalid    (arvalid),
    .arready    (arready),
    .ar         (ar)
);

// File: verification/lsu_tb.sv
`timescale 1ns/1ns

module lsu_tb;
    import lsu_pkg::*;

    localparam logic [31:0] MEM_BASE   = 32'h8000_0000;
    localparam int          MEM_WORDS  = 64;
    localparam int          MEM_BYTES  = MEM_WORDS * 4;
    localparam logic [31:0] WIN_BYTES  = 32'(MEM_BYTES);
    localparam int          WAIT_LIMIT = 200;

    logic      clk;
    logic      rst;
    logic      req_valid;
    lsu_req_t  req;
    logic      req_ready;
    logic      resp_valid;
    lsu_resp_t resp;

    logic [7:0]  model_mem [MEM_BYTES];
    logic [31:0] lfsr_state = 32'h42a4;
    int          errors     = 0;
    int          checks     = 0;
    int          accepted   = 0;
    int          responses  = 0;
    logic        hung       = 1'b0;

    tb_clk_gen #(
        .PERIOD       (40),
        .RESET_CYCLES (10)
    ) u_clk (
        .clk (clk),
        .rst (rst)
    );

    // upper half of the window is treated as sdram.
    lsu_top #(
        .SDRAM_BASE  (32'h8000_0080),
        .SDRAM_LIMIT (32'h8000_00ff),
        .MEM_BASE    (MEM_BASE),
        .MEM_WORDS   (MEM_WORDS),
        .RESP_DELAY  (2)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    always @(negedge clk) begin
        if (!rst && resp_valid) begin
            responses = responses + 1;
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic int byte_count(input mem_size_e size);
        case (size)
            MEM_BYTE: return 1;
            MEM_HALF: return 2;
            default:  return 4;
        endcase
    endfunction

    function automatic void model_store(input logic [31:0] addr, input mem_size_e size,
                                        input logic [31:0] data);
        int off;
        off = int'(addr - MEM_BASE);
        for (int i = 0; i < byte_count(size); i++) begin
            model_mem[off + i] = data[8*i +: 8];
        end
    endfunction

    // gather the bytes, then fill the upper bytes from the top bit.
    function automatic logic [31:0] model_load(input logic [31:0] addr, input mem_size_e size,
                                               input logic sx);
        logic [31:0] raw;
        int          off;
        int          n;
        raw = '0;
        off = int'(addr - MEM_BASE);
        n   = byte_count(size);
        for (int i = 0; i < n; i++) begin
            raw[8*i +: 8] = model_mem[off + i];
        end
        if (sx && raw[8*n-1]) begin
            for (int i = n; i < 4; i++) begin
                raw[8*i +: 8] = 8'hff;
            end
        end
        return raw;
    endfunction

    function automatic lsu_req_t make_req(input logic is_load, input logic is_store,
                                          input mem_size_e size, input logic sx,
                                          input logic [31:0] addr, input logic [31:0] wdata);
        lsu_req_t r;
        r.pc          = rand_bits(32);
        r.rd          = 5'(rand_bits(5));
        r.op.read     = is_load;
        r.op.write    = is_store;
        r.op.size     = size;
        r.op.sign_ext = sx;
        r.addr        = addr;
        r.wdata       = wdata;
        r.tag         = 8'(rand_bits(8));
        return r;
    endfunction

    function automatic lsu_resp_t expected_resp(input lsu_req_t r);
        lsu_resp_t e;
        logic      mem_op;
        logic      in_win;
        mem_op  = r.op.read || r.op.write;
        in_win  = (r.addr >= MEM_BASE) && ((r.addr - MEM_BASE) < WIN_BYTES);
        e.pc    = r.pc;
        e.rd    = r.rd;
        e.tag   = r.tag;
        e.fault = mem_op && !in_win;
        if (r.op.read) begin
            e.result = in_win ? model_load(r.addr, r.op.size, r.op.sign_ext) : 32'h0;
        end else begin
            e.result = r.addr;
        end
        return e;
    endfunction

    task automatic compare_resp(input lsu_resp_t got, input lsu_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR resp: got %h expected %h", got, exp);
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_hang(input string msg);
        $display("timeout: %s", msg);
        hung = 1'b1;
    endtask

    task automatic print_counts();
        $display("checks %0d, errors %0d, accepted %0d, responses %0d, timeout %0d",
                 checks, errors, accepted, responses, hung);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        @(negedge clk);
        while (rst && !hung) begin
            n++;
            if (n > WAIT_LIMIT) begin
                report_hang("reset never released");
            end
            @(negedge clk);
        end
        compare_word("req_ready", 32'(req_ready), 32'h1);
        compare_word("resp_valid", 32'(resp_valid), 32'h0);
    endtask

    task automatic send_req(input lsu_req_t r);
        int n;
        n = 0;
        @(negedge clk);
        while (!req_ready && !hung) begin
            n++;
            if (n > WAIT_LIMIT) begin
                report_hang("req_ready stayed low");
            end
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        @(posedge clk);
        req_valid <= 1'b0;
        accepted++;
    endtask

    // cycles counts from the accepting edge to the first cycle with resp_valid.
    task automatic wait_resp(output lsu_resp_t got, output int cycles);
        @(negedge clk);
        cycles = 1;
        while (!resp_valid && !hung) begin
            if (cycles >= WAIT_LIMIT) begin
                report_hang("no resp_valid after an accepted request");
            end
            @(negedge clk);
            cycles++;
        end
        got = resp;
        // the response cycle still counts as busy.
        compare_word("req_ready", 32'(req_ready), 32'h0);
    endtask

    task automatic run_access(input logic is_load, input logic is_store, input mem_size_e size,
                              input logic sx, input logic [31:0] addr, input logic [31:0] wdata);
        lsu_req_t  r;
        lsu_resp_t exp;
        lsu_resp_t got;
        int        cycles;
        r   = make_req(is_load, is_store, size, sx, addr, wdata);
        exp = expected_resp(r);
        send_req(r);
        wait_resp(got, cycles);
        compare_resp(got, exp);
        if (!is_load && !is_store) begin
            compare_word("pass-through latency", 32'(cycles), 32'h1);
        end
        if (is_store && !exp.fault) begin
            model_store(addr, size, wdata);
        end
    endtask

    task automatic preload_memory();
        logic [31:0] addr;
        for (int i = 0; i < MEM_WORDS; i++) begin
            addr = MEM_BASE + 32'(4 * i);
            run_access(1'b0, 1'b1, MEM_WORD, 1'b0, addr, fill_word(addr));
        end
    endtask

    task automatic pass_through_test();
        for (int i = 0; i < 4; i++) begin
            run_access(1'b0, 1'b0, MEM_WORD, 1'b0, rand_bits(32), rand_bits(32));
        end
    endtask

    task automatic word_test();
        logic [31:0] addr;
        for (int i = 0; i < 4; i++) begin
            addr = MEM_BASE + 32'(rand_bits(6)) * 4;
            run_access(1'b0, 1'b1, MEM_WORD, 1'b0, addr, rand_bits(32));
            run_access(1'b1, 1'b0, MEM_WORD, 1'b0, addr, 32'h0);
        end
    endtask

    // top lane bit is forced high so that sign and zero extension differ.
    task automatic lane_test();
        logic [31:0] base;
        base = MEM_BASE + 32'h40;
        for (int off = 0; off < 4; off++) begin
            run_access(1'b0, 1'b1, MEM_BYTE, 1'b0, base + 32'(off), rand_bits(32) | 32'h80);
            run_access(1'b1, 1'b0, MEM_BYTE, 1'b0, base + 32'(off), 32'h0);
            run_access(1'b1, 1'b0, MEM_BYTE, 1'b1, base + 32'(off), 32'h0);
        end
        // whole word shows whether a strobe touched a neighbouring lane.
        run_access(1'b1, 1'b0, MEM_WORD, 1'b0, base, 32'h0);
        for (int off = 0; off < 4; off += 2) begin
            run_access(1'b0, 1'b1, MEM_HALF, 1'b0, base + 32'(8 + off), rand_bits(32) | 32'h8000);
            run_access(1'b1, 1'b0, MEM_HALF, 1'b0, base + 32'(8 + off), 32'h0);
            run_access(1'b1, 1'b0, MEM_HALF, 1'b1, base + 32'(8 + off), 32'h0);
        end
        run_access(1'b1, 1'b0, MEM_WORD, 1'b0, base + 32'h8, 32'h0);
    endtask

    task automatic window_test();
        logic [31:0] above;
        logic [31:0] below;
        above = MEM_BASE + WIN_BYTES;
        below = MEM_BASE - 32'd4;
        run_access(1'b0, 1'b1, MEM_WORD, 1'b0, above, 32'hdead_beef);
        run_access(1'b0, 1'b1, MEM_WORD, 1'b0, below, 32'hdead_beef);
        run_access(1'b1, 1'b0, MEM_WORD, 1'b0, above, 32'h0);
        run_access(1'b1, 1'b0, MEM_WORD, 1'b0, below, 32'h0);
        // an aliased write would show up in the first or last word.
        run_access(1'b1, 1'b0, MEM_WORD, 1'b0, MEM_BASE, 32'h0);
        run_access(1'b1, 1'b0, MEM_WORD, 1'b0, MEM_BASE + WIN_BYTES - 32'd4, 32'h0);
    endtask

    task automatic random_mix_test();
        logic [1:0]  sel;
        mem_size_e   size;
        logic [31:0] off;
        logic [31:0] addr;
        logic        is_load;
        for (int i = 0; i < 60; i++) begin
            sel = 2'(rand_bits(2));
            case (sel)
                2'd0: begin
                    size = MEM_BYTE;
                    off  = rand_bits(2);
                end
                2'd1: begin
                    size = MEM_HALF;
                    off  = rand_bits(1) << 1;
                end
                default: begin
                    size = MEM_WORD;
                    off  = 32'h0;
                end
            endcase
            addr    = MEM_BASE + 32'(rand_bits(6)) * 4 + off;
            is_load = rand_bits(1) == 32'h1;
            run_access(is_load, !is_load, size, rand_bits(1) == 32'h1, addr, rand_bits(32));
        end
    endtask

    task automatic ready_rule_test();
        lsu_req_t  r;
        lsu_req_t  stray;
        lsu_resp_t exp;
        lsu_resp_t got;
        int        cycles;
        r     = make_req(1'b1, 1'b0, MEM_WORD, 1'b0, MEM_BASE + 32'h20, 32'h0);
        stray = make_req(1'b0, 1'b0, MEM_WORD, 1'b0, 32'h1234_5678, 32'h0);
        exp   = expected_resp(r);
        send_req(r);
        @(negedge clk);
        compare_word("req_ready", 32'(req_ready), 32'h0);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= stray;
        @(posedge clk);
        req_valid <= 1'b0;
        wait_resp(got, cycles);
        compare_resp(got, exp);
        // observation window for any late extra response.
        repeat (12) @(negedge clk);
        compare_word("response count", 32'(responses), 32'(accepted));
    endtask

    initial begin
        wait (hung);
        print_counts();
        $display("test failed");
        $finish;
    end

    initial begin
        req_valid = 1'b0;
        req       = '0;
        wait_reset();
        preload_memory();
        pass_through_test();
        word_test();
        lane_test();
        window_test();
        random_mix_test();
        ready_rule_test();
        compare_word("response count", 32'(responses), 32'(accepted));
        print_counts();
        if (errors == 0 && !hung) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: vlog.f
hdl/lsu_pkg.sv
hdl/lsu_data_align.sv
hdl/lsu_ctrl.sv
hdl/axi_mem_slave.sv
hdl/lsu_top.sv
verification/tb_clk_gen.sv
verification/lsu_checker.sv
verification/lsu_tb.sv
